// ==== hw/i2f_cast_core.sv ====
`timescale 1ns/1ps

module i2f_cast_core
  import i2f_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // FIFO head
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 sign_i,
  input  logic [INT_WIDTH-1:0] magnitude_i,
  input  round_mode_e          rnd_mode_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  // Result side
  output logic [FP_WIDTH-1:0]  result_o,
  output logic                 inexact_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  logic [SHAMT_WIDTH-1:0]       lz_count;
  logic                         mag_zero;
  logic [INT_WIDTH-1:0]         norm_mag;      // Leading one at the MSB
  logic [EXP_BITS-1:0]          pre_exp;
  logic [MAN_BITS-1:0]          pre_man;
  logic                         guard;
  logic                         sticky;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs;
  logic [EXP_BITS+MAN_BITS-1:0] rounded_abs;
  logic                         round_inexact;
  logic                         res_sign;
  logic [FP_WIDTH-1:0]          result_d;

  logic                         valid_q;
  logic [FP_WIDTH-1:0]          result_q;
  logic                         inexact_q;
  logic [TAG_WIDTH-1:0]         tag_q;

  // ------------------------------
  // Normalization
  // ------------------------------
  i2f_lzc i_lzc (
    .value_i (magnitude_i),
    .count_o (lz_count),
    .zero_o  (mag_zero)
  );

  assign norm_mag = magnitude_i << lz_count;

  // Hidden bit is norm_mag[31], dropped here
  assign pre_man = norm_mag[INT_WIDTH-2 -: MAN_BITS];
  assign guard   = norm_mag[INT_WIDTH-MAN_BITS-2];
  assign sticky  = |norm_mag[INT_WIDTH-MAN_BITS-3:0];

  // Value is 1.m * 2^(31 - count), biased
  always_comb begin
    if (mag_zero) begin
      pre_exp = '0;  // Zero encodes with a zero exponent
    end else begin
      pre_exp = EXP_BITS'(FP_BIAS + INT_WIDTH - 1) - EXP_BITS'(lz_count);
    end
  end

  assign pre_round_abs = {pre_exp, pre_man};
  assign res_sign      = sign_i & ~mag_zero;  // Zero is always +0

  // ------------------------------
  // Rounding
  // ------------------------------
  i2f_rounder i_rounder (
    .abs_value_i   (pre_round_abs),
    .sign_i        (res_sign),
    .guard_i       (guard),
    .sticky_i      (sticky),
    .rnd_mode_i    (rnd_mode_i),
    .abs_rounded_o (rounded_abs),
    .inexact_o     (round_inexact)
  );

  assign result_d = {res_sign, rounded_abs};

  // ------------------------------
  // Output register
  // ------------------------------
  assign in_ready_o = ~valid_q | out_ready_i;  // Empty or draining

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Held stable while stalled
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      result_q  <= result_d;
      inexact_q <= round_inexact;
      tag_q     <= tag_i;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = result_q;
  assign inexact_o   = inexact_q;
  assign tag_o       = tag_q;

endmodule

// ==== hw/i2f_fifo.sv ====
`timescale 1ns/1ps

module i2f_fifo
  import i2f_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Write side
  input  logic                 wr_valid_i,
  output logic                 wr_ready_o,
  input  logic                 wr_sign_i,
  input  logic [INT_WIDTH-1:0] wr_magnitude_i,
  input  round_mode_e          wr_rnd_mode_i,
  input  logic [TAG_WIDTH-1:0] wr_tag_i,
  // Read side
  output logic                 rd_valid_o,
  input  logic                 rd_ready_i,
  output logic                 rd_sign_o,
  output logic [INT_WIDTH-1:0] rd_magnitude_o,
  output round_mode_e          rd_rnd_mode_o,
  output logic [TAG_WIDTH-1:0] rd_tag_o
);

  localparam int unsigned PtrWidth = $clog2(FifoDepth);
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  // Storage, one slot per entry
  logic                 sign_mem [FifoDepth];
  logic [INT_WIDTH-1:0] mag_mem  [FifoDepth];
  round_mode_e          mode_mem [FifoDepth];
  logic [TAG_WIDTH-1:0] tag_mem  [FifoDepth];

  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;   // Occupancy, 0..FifoDepth
  logic                 push;
  logic                 pop;

  // ------------------------------
  // Flags and handshake
  // ------------------------------
  assign wr_ready_o = (count_q != CntWidth'(FifoDepth));  // Full blocks even with a pop
  assign rd_valid_o = (count_q != '0);
  assign push       = wr_valid_i & wr_ready_o;
  assign pop        = rd_valid_o & rd_ready_i;

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin  // Explicit wrap, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or push+pop
      endcase
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push) begin
      sign_mem[wr_ptr_q] <= wr_sign_i;
      mag_mem[wr_ptr_q]  <= wr_magnitude_i;
      mode_mem[wr_ptr_q] <= wr_rnd_mode_i;
      tag_mem[wr_ptr_q]  <= wr_tag_i;
    end
  end

  // Head of queue, registered entries only
  assign rd_sign_o      = sign_mem[rd_ptr_q];
  assign rd_magnitude_o = mag_mem[rd_ptr_q];
  assign rd_rnd_mode_o  = mode_mem[rd_ptr_q];
  assign rd_tag_o       = tag_mem[rd_ptr_q];

endmodule

// ==== hw/i2f_lzc.sv ====
`timescale 1ns/1ps

module i2f_lzc
  import i2f_pkg::*;
(
  input  logic [INT_WIDTH-1:0]   value_i,
  output logic [SHAMT_WIDTH-1:0] count_o,
  output logic                   zero_o
);

  // ------------------------------
  // Priority search
  // ------------------------------
  // Scan upward so the highest set bit wins
  always_comb begin
    count_o = '0;  // Also the count for an all-zero value
    for (int unsigned i = 0; i < INT_WIDTH; i++) begin
      if (value_i[i]) begin
        count_o = SHAMT_WIDTH'(INT_WIDTH - 1 - i);
      end
    end
  end

  // No leading one at all
  assign zero_o = ~|value_i;

endmodule

// ==== hw/i2f_operand_stage.sv ====
`timescale 1ns/1ps

module i2f_operand_stage
  import i2f_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Operand side
  input  logic [INT_WIDTH-1:0] operand_i,
  input  int_fmt_e             int_fmt_i,
  input  logic                 unsigned_i,
  input  round_mode_e          rnd_mode_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  // Prepared operand towards the FIFO
  output logic                 sign_o,
  output logic [INT_WIDTH-1:0] magnitude_o,
  output round_mode_e          rnd_mode_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  logic [INT_WIDTH-1:0] ext_val;    // Operand widened to 32 bits
  logic                 in_sign;
  logic [INT_WIDTH-1:0] in_mag;

  logic                 valid_q;
  logic                 sign_q;
  logic [INT_WIDTH-1:0] mag_q;
  round_mode_e          rnd_mode_q;
  logic [TAG_WIDTH-1:0] tag_q;

  // ------------------------------
  // Extension and magnitude
  // ------------------------------
  always_comb begin
    int unsigned          fmt_width;
    logic [INT_WIDTH-1:0] ext_mask;
    logic                 ext_bit;
    fmt_width = int_width(int_fmt_i);
    ext_mask  = {INT_WIDTH{1'b1}} << fmt_width;  // Bits above the format, empty for INT32
    // Top bit of the format replicates upward, zeros when unsigned
    ext_bit   = operand_i[fmt_width-1] & ~unsigned_i;
    ext_val   = (ext_mask & {INT_WIDTH{ext_bit}}) | (~ext_mask & operand_i);
  end

  assign in_sign = ext_val[INT_WIDTH-1] & ~unsigned_i;
  // Two's complement negate, -2^31 maps to 0x80000000 as wanted
  assign in_mag  = in_sign ? (~ext_val + 1'b1) : ext_val;

  // ------------------------------
  // One-entry stage
  // ------------------------------
  // Free when empty or when the held entry leaves this cycle
  assign in_ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;  // Drops to 0 on a drain with no new input
    end
  end

  // Payload loads on accept only
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      sign_q     <= in_sign;
      mag_q      <= in_mag;
      rnd_mode_q <= rnd_mode_i;
      tag_q      <= tag_i;
    end
  end

  assign valid_o     = valid_q;
  assign sign_o      = sign_q;
  assign magnitude_o = mag_q;
  assign rnd_mode_o  = rnd_mode_q;
  assign tag_o       = tag_q;

endmodule

// ==== hw/i2f_pkg.sv ====
package i2f_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned INT_WIDTH   = 32;  // Integer operand and magnitude
  localparam int unsigned EXP_BITS    = 8;   // Single precision exponent
  localparam int unsigned MAN_BITS    = 23;  // Stored mantissa, hidden bit excluded
  localparam int unsigned FP_WIDTH    = 32;  // Sign + exponent + mantissa
  localparam int unsigned FP_BIAS     = 127;
  localparam int unsigned SHAMT_WIDTH = 5;   // Enough for a 0..31 leading-zero count
  localparam int unsigned TAG_WIDTH   = 4;

  // ------------------------------
  // Encodings
  // ------------------------------
  // Source integer format
  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    INT32 = 2'd2
  } int_fmt_e;

  // Rounding mode, RISC-V frm encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,  // Nearest, ties to even
    RTZ = 3'b001,  // Toward zero
    RDN = 3'b010,  // Toward -inf
    RUP = 3'b011,  // Toward +inf
    RMM = 3'b100   // Nearest, ties away from zero
  } round_mode_e;

  // Number of significant bits for a source format
  function automatic int unsigned int_width(int_fmt_e fmt);
    case (fmt)
      INT8:    return 8;
      INT16:   return 16;
      default: return 32;  // INT32 and unused code
    endcase
  endfunction

endpackage

// ==== hw/i2f_rounder.sv ====
`timescale 1ns/1ps

module i2f_rounder
  import i2f_pkg::*;
(
  input  logic [EXP_BITS+MAN_BITS-1:0] abs_value_i,  // Packed exponent and mantissa
  input  logic                         sign_i,
  input  logic                         guard_i,      // First dropped bit
  input  logic                         sticky_i,     // OR of the rest
  input  round_mode_e                  rnd_mode_i,
  output logic [EXP_BITS+MAN_BITS-1:0] abs_rounded_o,
  output logic                         inexact_o
);

  logic round_up;
  logic lost;  // Any dropped bit set

  assign lost = guard_i | sticky_i;

  // ------------------------------
  // Round-up decision
  // ------------------------------
  always_comb begin
    case (rnd_mode_i)
      RNE:     round_up = guard_i & (sticky_i | abs_value_i[0]);  // Tie goes to even lsb
      RTZ:     round_up = 1'b0;
      RDN:     round_up = lost & sign_i;    // Magnitude grows for negatives
      RUP:     round_up = lost & ~sign_i;   // Magnitude grows for positives
      RMM:     round_up = guard_i;          // Ties away from zero
      default: round_up = 1'b0;             // Reserved encodings truncate
    endcase
  end

  // Mantissa overflow carries straight into the exponent field
  assign abs_rounded_o = abs_value_i + {{(EXP_BITS+MAN_BITS-1){1'b0}}, round_up};
  assign inexact_o     = lost;

endmodule

// ==== hw/i2f_top.sv ====
`timescale 1ns/1ps

module i2f_top
  import i2f_pkg::*;
#(
  parameter int unsigned FifoDepth = 4  // Entries between the two stages
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Operand in
  input  logic [INT_WIDTH-1:0] operand_i,
  input  int_fmt_e             int_fmt_i,
  input  logic                 unsigned_i,
  input  round_mode_e          rnd_mode_i,
  input  logic [TAG_WIDTH-1:0] tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  // Result out
  output logic [FP_WIDTH-1:0]  result_o,
  output logic                 inexact_o,
  output logic [TAG_WIDTH-1:0] tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  // ------------------------------
  // Internal links
  // ------------------------------
  logic                 op_valid;      // Operand stage to FIFO
  logic                 op_ready;
  logic                 op_sign;
  logic [INT_WIDTH-1:0] op_magnitude;
  round_mode_e          op_rnd_mode;
  logic [TAG_WIDTH-1:0] op_tag;

  logic                 fifo_valid;    // FIFO to cast core
  logic                 fifo_ready;
  logic                 fifo_sign;
  logic [INT_WIDTH-1:0] fifo_magnitude;
  round_mode_e          fifo_rnd_mode;
  logic [TAG_WIDTH-1:0] fifo_tag;

  i2f_operand_stage i_operand_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operand_i   (operand_i),
    .int_fmt_i   (int_fmt_i),
    .unsigned_i  (unsigned_i),
    .rnd_mode_i  (rnd_mode_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .sign_o      (op_sign),
    .magnitude_o (op_magnitude),
    .rnd_mode_o  (op_rnd_mode),
    .tag_o       (op_tag),
    .valid_o     (op_valid),
    .ready_i     (op_ready)
  );

  i2f_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wr_valid_i     (op_valid),
    .wr_ready_o     (op_ready),
    .wr_sign_i      (op_sign),
    .wr_magnitude_i (op_magnitude),
    .wr_rnd_mode_i  (op_rnd_mode),
    .wr_tag_i       (op_tag),
    .rd_valid_o     (fifo_valid),
    .rd_ready_i     (fifo_ready),
    .rd_sign_o      (fifo_sign),
    .rd_magnitude_o (fifo_magnitude),
    .rd_rnd_mode_o  (fifo_rnd_mode),
    .rd_tag_o       (fifo_tag)
  );

  i2f_cast_core i_cast_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (fifo_valid),
    .in_ready_o  (fifo_ready),
    .sign_i      (fifo_sign),
    .magnitude_i (fifo_magnitude),
    .rnd_mode_i  (fifo_rnd_mode),
    .tag_i       (fifo_tag),
    .result_o    (result_o),
    .inexact_o   (inexact_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// ==== i2f.f ====
hw/i2f_pkg.sv
hw/i2f_lzc.sv
hw/i2f_rounder.sv
hw/i2f_operand_stage.sv
hw/i2f_fifo.sv
hw/i2f_cast_core.sv
hw/i2f_top.sv
verification/i2f_tb.sv

// ==== verification/i2f_tb.sv ====
`timescale 1ns/1ps

module i2f_tb
  import i2f_pkg::*;
;

  localparam int unsigned FifoDepth  = 4;
  localparam int          Timeout    = 1000;  // Cycles per wait loop
  localparam int          StreamOps  = 300;

  logic                 clk;
  logic                 rst_n;
  logic [INT_WIDTH-1:0] operand;
  int_fmt_e             int_fmt;
  logic                 is_unsigned;
  round_mode_e          rnd_mode;
  logic [TAG_WIDTH-1:0] tag;
  logic                 in_valid;
  logic                 in_ready;
  logic [FP_WIDTH-1:0]  result;
  logic                 inexact;
  logic [TAG_WIDTH-1:0] tag_out;
  logic                 out_valid;
  logic                 out_ready;

  int                   seed = 32'hf185_b5f4;
  int                   next_tag;
  int                   accepted;    // Input handshakes seen
  int                   delivered;   // Output handshakes seen
  int                   in_stalls;   // Edges with in_ready low
  logic [FP_WIDTH-1:0]  exp_result_q [$];
  logic                 exp_inexact_q [$];
  logic [TAG_WIDTH-1:0] exp_tag_q [$];

  i2f_top #(
    .FifoDepth (FifoDepth)
  ) i2f_top_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_i   (operand),
    .int_fmt_i   (int_fmt),
    .unsigned_i  (is_unsigned),
    .rnd_mode_i  (rnd_mode),
    .tag_i       (tag),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .inexact_o   (inexact),
    .tag_o       (tag_out),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("Fail %s expected %0h actual %0h", name, expected, actual);
    end_with_failure();
  endtask

  task automatic hard_failure(input string what);
    $display("%s", what);
    end_with_failure();
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Returns {inexact, sign, exponent, mantissa}
  function automatic logic [32:0] convert_model(input logic [31:0] op, input int_fmt_e fmt,
                                                input logic uns, input round_mode_e mode);
    int unsigned        w;
    int                 msb;
    logic [63:0]        mask;
    logic signed [63:0] value;
    logic [63:0]        mag;
    logic [63:0]        kept;
    logic [63:0]        rem;    // Dropped low bits as an integer
    logic [63:0]        half;   // Weight of half an ulp
    logic               neg;
    logic               up;
    logic [30:0]        body;
    w     = int_width(fmt);
    mask  = (64'd1 << w) - 1;
    value = $signed({32'd0, op} & mask);
    if (!uns && op[w-1]) value = value - (64'sd1 <<< w);  // Two's complement of the format
    neg = (value < 0);
    mag = neg ? -value : value;
    if (mag == 0) return 33'd0;
    msb = 32;
    while (!mag[msb]) msb--;
    if (msb <= 23) begin
      kept = mag << (23 - msb);  // Fits, nothing lost
      rem  = 0;
      half = 1;
    end else begin
      kept = mag >> (msb - 23);
      rem  = mag & ((64'd1 << (msb - 23)) - 1);
      half = 64'd1 << (msb - 24);
    end
    case (mode)
      RNE:     up = (rem > half) || ((rem == half) && kept[0]);
      RTZ:     up = 1'b0;
      RDN:     up = neg && (rem != 0);
      RUP:     up = !neg && (rem != 0);
      RMM:     up = (rem >= half) && (rem != 0);
      default: up = 1'b0;
    endcase
    body = {8'(127 + msb), kept[22:0]} + 31'(up);  // Carry may bump the exponent
    return {rem != 0, neg, body};
  endfunction

  // ------------------------------
  // Monitors
  // ------------------------------
  always @(posedge clk) begin
    logic [32:0] modeled;
    if (rst_n) begin
      if (!in_ready) begin  // Full pipe only
        in_stalls++;
        assert (accepted - delivered >= FifoDepth + 2)
          else value_mismatch("in_ready_o outstanding", FifoDepth + 2, accepted - delivered);
      end
      if (in_valid && in_ready) begin
        modeled = convert_model(operand, int_fmt, is_unsigned, rnd_mode);
        exp_result_q.push_back(modeled[31:0]);
        exp_inexact_q.push_back(modeled[32]);
        exp_tag_q.push_back(tag);
        accepted++;
      end
      if (out_valid && out_ready) begin
        assert (exp_result_q.size() != 0) else hard_failure("result came out with none pending");
        assert (result == exp_result_q[0])
          else value_mismatch("result_o", exp_result_q[0], result);
        assert (inexact == exp_inexact_q[0])
          else value_mismatch("inexact_o", exp_inexact_q[0], inexact);
        assert (tag_out == exp_tag_q[0]) else value_mismatch("tag_o", exp_tag_q[0], tag_out);
        void'(exp_result_q.pop_front());
        void'(exp_inexact_q.pop_front());
        void'(exp_tag_q.pop_front());
        delivered++;
      end
    end
  end

  // Stalled outputs must hold
  always @(posedge clk) begin
    logic                 held;
    logic [FP_WIDTH-1:0]  held_result;
    logic                 held_inexact;
    logic [TAG_WIDTH-1:0] held_tag;
    if (rst_n && held) begin
      assert (out_valid) else hard_failure("out_valid_o dropped while stalled");
      assert (result == held_result) else value_mismatch("result_o", held_result, result);
      assert (inexact == held_inexact) else value_mismatch("inexact_o", held_inexact, inexact);
      assert (tag_out == held_tag) else value_mismatch("tag_o", held_tag, tag_out);
    end
    held         = rst_n && out_valid && !out_ready;
    held_result  = result;
    held_inexact = inexact;
    held_tag     = tag_out;
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic send_op(input logic [31:0] op, input int_fmt_e fmt, input logic uns,
                         input round_mode_e mode);
    int waited;
    waited      = 0;
    operand     = op;
    int_fmt     = fmt;
    is_unsigned = uns;
    rnd_mode    = mode;
    tag         = next_tag[TAG_WIDTH-1:0];
    in_valid    = 1'b1;
    while (!in_ready) begin
      if (waited == Timeout) hard_failure("in_ready_o stuck low while sending");
      @(negedge clk);
      waited++;
    end
    @(posedge clk);  // Accepting edge
    @(negedge clk);
    in_valid = 1'b0;
    next_tag++;
  endtask

  task automatic check_directed(input logic [31:0] op, input int_fmt_e fmt, input logic uns,
                                input round_mode_e mode, input logic [32:0] expected);
    logic [32:0] modeled;
    modeled = convert_model(op, fmt, uns, mode);
    assert (modeled == expected) else value_mismatch("model result", expected, modeled);
    send_op(op, fmt, uns, mode);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (accepted != delivered) begin
      if (waited == Timeout) hard_failure("pipe did not drain in time");
      @(negedge clk);
      waited++;
    end
  endtask

  // Back-to-back input with random output ready
  task automatic run_stream(input int count);
    int   sent;
    int   stuck;
    logic took;
    sent  = 0;
    stuck = 0;
    while (sent < count) begin
      if (!in_valid) begin  // New op, a stalled one stays put
        operand     = $random(seed);
        int_fmt     = int_fmt_e'($unsigned($random(seed)) % 3);
        is_unsigned = $random(seed) & 1;
        rnd_mode    = round_mode_e'($unsigned($random(seed)) % 5);
        tag         = next_tag[TAG_WIDTH-1:0];
        in_valid    = 1'b1;
      end
      out_ready = $random(seed) & 1;
      took      = in_ready;  // Stable up to the rising edge
      @(posedge clk);
      @(negedge clk);
      if (took) begin
        sent++;
        next_tag++;
        stuck    = 0;
        in_valid = 1'b0;
      end else begin
        stuck++;
        if (stuck == Timeout) hard_failure("input stream stalled too long");
      end
    end
    out_ready = 1'b1;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] round_vals [6];
    int          edges;
    rst_n       = 1'b0;
    operand     = '0;
    int_fmt     = INT32;
    is_unsigned = 1'b0;
    rnd_mode    = RNE;
    tag         = '0;
    in_valid    = 1'b0;
    out_ready   = 1'b1;
    next_tag    = 0;
    accepted    = 0;
    delivered   = 0;
    in_stalls   = 0;
    round_vals  = '{32'h7FFF_FFFF, 32'h8000_0001, 32'h0100_0001,
                    32'h0100_0003, 32'hFEFF_FFFD, 32'h1234_5679};
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!out_valid) else value_mismatch("out_valid_o", 0, out_valid);
    assert (in_ready) else value_mismatch("in_ready_o", 1, in_ready);

    // Exact values, extension per format
    check_directed(32'h0000_0000, INT32, 1'b0, RNE, 33'h0_0000_0000);
    check_directed(32'h0000_00FF, INT8,  1'b0, RNE, 33'h0_BF80_0000);
    check_directed(32'hABCD_1280, INT8,  1'b0, RTZ, 33'h0_C300_0000);  // Upper bits ignored
    check_directed(32'h0000_FFFF, INT16, 1'b1, RNE, 33'h0_477F_FF00);
    check_directed(32'h0000_8000, INT16, 1'b0, RUP, 33'h0_C700_0000);
    check_directed(32'h0000_0005, INT32, 1'b0, RDN, 33'h0_40A0_0000);
    check_directed(32'hFFFF_FF9C, INT32, 1'b0, RMM, 33'h0_C2C8_0000);
    check_directed(32'h7FFF_FFFF, INT32, 1'b0, RUP, 33'h1_4F00_0000);  // Carry into exponent
    wait_drained();

    // Every mode on wide values
    for (int u = 0; u < 2; u++) begin
      for (int m = 0; m < 5; m++) begin
        foreach (round_vals[i]) send_op(round_vals[i], INT32, u[0], round_mode_e'(m));
      end
    end
    wait_drained();

    // Single op latency, accepting edge counts as first
    send_op(32'h0000_0300, INT32, 1'b0, RNE);
    edges = 1;
    while (!out_valid) begin
      if (edges == Timeout) hard_failure("out_valid_o never rose");
      @(negedge clk);
      edges++;
    end
    assert (edges == 3) else value_mismatch("out_valid_o latency", 3, edges);
    wait_drained();

    run_stream(StreamOps);
    wait_drained();

    if (exp_result_q.size() == 0 && in_stalls > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Pending results %0d, input stall edges %0d", exp_result_q.size(), in_stalls);
      end_with_failure();
    end
  end

endmodule
